// ==== compile.f ====
+incdir+.
dma_pkg.sv
dma_cfg_if.sv
dma_regs.sv
dma_addr_unit.sv
dma_engine.sv
dma_channel.sv
tb_clock_gen.sv
dma_checker.sv
dma_props.sv
dma_tb.sv

// ==== dma_addr_unit.sv ====
`timescale 1ns/1ns
`include "dma_config.svh"

module dma_addr_unit import dma_pkg::*; (
    input  logic                    clk100,
    input  logic                    reset,
    input  logic                    load,
    input  logic [`DMA_ADDR_W-1:0]  load_addr,
    input  logic                    step,
    input  addr_ctl_t               ctl,
    input  xfer_width_t             width,
    input  logic                    force_incr,     // rom window on the source side
    input  logic                    reload,
    output logic [`DMA_ADDR_W-1:0]  addr
);

    logic [`DMA_ADDR_W-1:0] aligned;
    logic [`DMA_ADDR_W-1:0] stride;

    // halfword keeps bit 1, it picks the lane
    always_comb begin
        aligned    = load_addr;
        aligned[0] = 1'b0;
        if (width == width_word)
            aligned[1] = 1'b0;
    end

    assign stride = (width == width_word) ? `DMA_ADDR_W'(4) : `DMA_ADDR_W'(2);

    always_ff @(posedge clk100) begin
        if (reset) begin
            addr <= '0;
        end else if (load || (reload && ctl == addr_incr_reload)) begin
            addr <= aligned;
        end else if (step) begin
            if (force_incr || ctl == addr_incr || ctl == addr_incr_reload)
                addr <= addr + stride;
            else if (ctl == addr_decr)
                addr <= addr - stride;
        end
    end

endmodule

// ==== dma_cfg_if.sv ====
`timescale 1ns/1ns
`include "dma_config.svh"

interface dma_cfg_if import dma_pkg::*; ();

    dma_ctrl_t                 ctrl;           // latched on enable rising
    logic [`DMA_ADDR_W-1:0]    sad;
    logic [`DMA_ADDR_W-1:0]    dad;            // live value, also used for reload
    logic [`DMA_ITEMS_W-1:0]   count_load;     // 0 already expanded to max
    logic                      arm;
    logic                      abort;
    logic                      done_disable;   // end of transfer without repeat

    modport regs (
        output ctrl,
        output sad,
        output dad,
        output count_load,
        output arm,
        output abort,
        input  done_disable
    );

    modport engine (
        input  ctrl,
        input  sad,
        input  dad,
        input  count_load,
        input  arm,
        input  abort,
        output done_disable
    );

endinterface

// ==== dma_channel.sv ====
`timescale 1ns/1ns
`include "dma_config.svh"

module dma_channel (
    input  logic                        clk100,
    input  logic                        reset,
    // register port
    input  logic                        reg_ena,
    input  logic                        reg_rnw,
    input  logic [`DMA_REG_ADR_W-1:0]   reg_adr,
    input  logic [3:0]                  reg_be,
    input  logic [31:0]                 reg_din,
    output logic [31:0]                 reg_dout,
    output logic                        reg_dout_valid,
    // start triggers
    input  logic                        vblank_trigger,
    input  logic                        hblank_trigger,
    // memory port
    output logic                        mem_ena,
    output logic                        mem_rnw,
    output logic [`DMA_ADDR_W-1:0]      mem_adr,
    output logic                        mem_wide,
    output logic [`DMA_DATA_W-1:0]      mem_dout,
    input  logic [`DMA_DATA_W-1:0]      mem_din,
    input  logic                        mem_done,
    output logic                        irq,
    output logic                        busy
);

    dma_cfg_if cfg_i ();

    dma_regs regs_i (
        .clk100         (clk100),
        .reset          (reset),
        .reg_ena        (reg_ena),
        .reg_rnw        (reg_rnw),
        .reg_adr        (reg_adr),
        .reg_be         (reg_be),
        .reg_din        (reg_din),
        .reg_dout       (reg_dout),
        .reg_dout_valid (reg_dout_valid),
        .cfg            (cfg_i.regs)
    );

    dma_engine engine_i (
        .clk100         (clk100),
        .reset          (reset),
        .cfg            (cfg_i.engine),
        .vblank_trigger (vblank_trigger),
        .hblank_trigger (hblank_trigger),
        .mem_ena        (mem_ena),
        .mem_rnw        (mem_rnw),
        .mem_adr        (mem_adr),
        .mem_wide       (mem_wide),
        .mem_dout       (mem_dout),
        .mem_din        (mem_din),
        .mem_done       (mem_done),
        .irq            (irq),
        .busy           (busy)
    );

endmodule

// ==== dma_checker.sv ====
`timescale 1ns/1ns
`include "dma_config.svh"

module dma_checker (
    input  logic                    clk100,
    input  logic                    reset,
    input  logic                    mem_ena,
    input  logic                    mem_rnw,
    input  logic [`DMA_ADDR_W-1:0]  mem_adr,
    input  logic                    mem_wide,
    input  logic [31:0]             mem_dout,
    input  logic                    mem_done,
    input  logic                    irq
);

    logic [60:0] exp_q[$];      // {wide, address, data} in write order
    int          err_count  = 0;
    int          test_errs  = 0;
    int          tests_run  = 0;
    int          tests_bad  = 0;
    int          write_cnt  = 0;
    int          irq_cnt    = 0;

    task automatic expect_write(input logic [60:0] item);
        exp_q.push_back(item);
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        err_count++;
        test_errs++;
    endtask

    // compare each completed write
    always @(posedge clk100) begin
        logic [60:0] e;
        if (!reset) begin
            if (irq)
                irq_cnt++;
            if (mem_ena && !mem_rnw && mem_done) begin
                write_cnt++;
                if (exp_q.size() == 0) begin
                    note_failure($sformatf("unexpected write to address %h", mem_adr));
                end else begin
                    e = exp_q.pop_front();
                    if (mem_wide !== e[60]) begin
                        $display("ERR mem_wide exp %h got %h", e[60], mem_wide);
                        err_count++;
                        test_errs++;
                    end
                    if (mem_adr !== e[59:32]) begin
                        $display("ERR mem_adr exp %h got %h", e[59:32], mem_adr);
                        err_count++;
                        test_errs++;
                    end
                    if (mem_dout !== e[31:0]) begin
                        $display("ERR mem_dout exp %h got %h", e[31:0], mem_dout);
                        err_count++;
                        test_errs++;
                    end
                end
            end
        end
    end

    task automatic end_test(input string name, input int exp_writes, input int exp_irqs);
        if (exp_q.size() != 0)
            note_failure($sformatf("%0d expected writes never happened", exp_q.size()));
        if (write_cnt != exp_writes) begin
            $display("ERR write_count exp %h got %h", exp_writes, write_cnt);
            err_count++;
            test_errs++;
        end
        if (irq_cnt != exp_irqs) begin
            $display("ERR irq_count exp %h got %h", exp_irqs, irq_cnt);
            err_count++;
            test_errs++;
        end
        tests_run++;
        if (test_errs != 0)
            tests_bad++;
        $display("test %s: %s (%0d writes)", name, test_errs ? "FAILED" : "ok", write_cnt);
        exp_q.delete();
        test_errs = 0;
        write_cnt = 0;
        irq_cnt   = 0;
    endtask

endmodule

// ==== dma_config.svh ====
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// memory side
`define DMA_ADDR_W      28
`define DMA_DATA_W      32

// word count field and the expanded item counter
`define DMA_COUNT_W     14
`define DMA_ITEMS_W     15
`define DMA_COUNT_MAX   16384           // what a written count of 0 means

// register port, word offsets
`define DMA_REG_ADR_W   2
`define DMA_REG_SAD     2'd0
`define DMA_REG_DAD     2'd1
`define DMA_REG_CNT     2'd2

// cartridge rom window
`define DMA_ROM_LO      28'h8000000
`define DMA_ROM_HI      28'hE000000     // exclusive

`endif

// ==== dma_engine.sv ====
`timescale 1ns/1ns
`include "dma_config.svh"

module dma_engine import dma_pkg::*; (
    input  logic                    clk100,
    input  logic                    reset,
    dma_cfg_if.engine               cfg,
    input  logic                    vblank_trigger,
    input  logic                    hblank_trigger,
    output logic                    mem_ena,
    output logic                    mem_rnw,
    output logic [`DMA_ADDR_W-1:0]  mem_adr,
    output logic                    mem_wide,
    output logic [`DMA_DATA_W-1:0]  mem_dout,
    input  logic [`DMA_DATA_W-1:0]  mem_din,
    input  logic                    mem_done,
    output logic                    irq,
    output logic                    busy
);

    localparam int HALF = `DMA_DATA_W / 2;

    engine_state_t            state_q;
    logic [`DMA_ITEMS_W-1:0]  items_q;      // items still to move, incl. current
    logic                     req_q;
    logic                     abort_q;      // abort waiting for the bus to finish
    logic                     end_q;
    logic                     done_disable_q;
    logic [`DMA_DATA_W-1:0]   wdata_q;

    logic [`DMA_ADDR_W-1:0]   src_addr;
    logic [`DMA_ADDR_W-1:0]   dst_addr;
    logic                     arm_ok;
    logic                     start_hit;
    logic                     src_in_rom;
    logic                     read_done;
    logic                     write_done;
    logic                     last_item;
    logic                     abort_pend;
    logic                     rearm;
    logic                     fin;

    assign arm_ok     = cfg.arm && state_q == st_idle;
    assign start_hit  = cfg.ctrl.start == start_immediate ||
                        (cfg.ctrl.start == start_vblank && vblank_trigger) ||
                        (cfg.ctrl.start == start_hblank && hblank_trigger);
    assign src_in_rom = src_addr >= `DMA_ROM_LO && src_addr < `DMA_ROM_HI;
    assign read_done  = state_q == st_reading && req_q && mem_done;
    assign write_done = state_q == st_writing && req_q && mem_done;
    assign last_item  = items_q == `DMA_ITEMS_W'(1);
    assign abort_pend = cfg.abort || abort_q;
    assign rearm      = cfg.ctrl.repeat_on && cfg.ctrl.start != start_immediate;
    assign fin        = write_done && last_item && !abort_pend;

    dma_addr_unit src_addr_i (
        .clk100     (clk100),
        .reset      (reset),
        .load       (arm_ok),
        .load_addr  (cfg.sad),
        .step       (read_done),
        .ctl        (cfg.ctrl.src_ctl),
        .width      (cfg.ctrl.width),
        .force_incr (src_in_rom),
        .reload     (1'b0),             // source is never reloaded on repeat
        .addr       (src_addr)
    );

    dma_addr_unit dst_addr_i (
        .clk100     (clk100),
        .reset      (reset),
        .load       (arm_ok),
        .load_addr  (cfg.dad),
        .step       (write_done),
        .ctl        (cfg.ctrl.dest_ctl),
        .width      (cfg.ctrl.width),
        .force_incr (1'b0),
        .reload     (fin && rearm),
        .addr       (dst_addr)
    );

    always_ff @(posedge clk100) begin
        if (reset) begin
            state_q        <= st_idle;
            items_q        <= '0;
            req_q          <= 1'b0;
            abort_q        <= 1'b0;
            irq            <= 1'b0;
            end_q          <= 1'b0;
            done_disable_q <= 1'b0;
        end else begin
            irq            <= fin && cfg.ctrl.irq_on;
            end_q          <= fin;
            done_disable_q <= fin && !rearm;
            case (state_q)
                st_idle: begin
                    if (arm_ok) begin
                        state_q <= st_waiting;
                        items_q <= cfg.count_load;
                    end
                end
                st_waiting: begin
                    if (cfg.abort)
                        state_q <= st_idle;
                    else if (start_hit)
                        state_q <= st_reading;
                end
                default: begin      // reading or writing
                    if (req_q) begin
                        if (mem_done) begin
                            req_q <= 1'b0;
                            if (abort_pend) begin
                                state_q <= st_idle;
                                abort_q <= 1'b0;
                            end else if (state_q == st_reading) begin
                                state_q <= st_writing;
                            end else if (!last_item) begin
                                state_q <= st_reading;
                                items_q <= items_q - 1'b1;
                            end else if (rearm) begin
                                state_q <= st_waiting;  // wait for the next trigger
                                items_q <= cfg.count_load;
                            end else begin
                                state_q <= st_idle;
                            end
                        end else if (cfg.abort) begin
                            abort_q <= 1'b1;
                        end
                    end else if (abort_pend) begin
                        state_q <= st_idle;
                        abort_q <= 1'b0;
                    end else begin
                        req_q <= 1'b1;  // bus idle for one cycle between requests
                    end
                end
            endcase
        end
    end

    // read data lane select, halfwords go out on both halves
    always_ff @(posedge clk100) begin
        if (read_done) begin
            if (cfg.ctrl.width == width_word)
                wdata_q <= mem_din;
            else if (src_addr[1])
                wdata_q <= {2{mem_din[`DMA_DATA_W-1:HALF]}};
            else
                wdata_q <= {2{mem_din[HALF-1:0]}};
        end
    end

    assign mem_ena          = req_q;
    assign mem_rnw          = state_q != st_writing;
    assign mem_adr          = (state_q == st_writing) ? dst_addr : src_addr;
    assign mem_wide         = cfg.ctrl.width == width_word;
    assign mem_dout         = wdata_q;
    assign busy             = state_q != st_idle || end_q;
    assign cfg.done_disable = done_disable_q;

endmodule

// ==== dma_pkg.sv ====
package dma_pkg;

    // address step control, same encoding as the cnt register
    typedef enum logic [1:0] {
        addr_incr        = 2'd0,
        addr_decr        = 2'd1,
        addr_fixed       = 2'd2,
        addr_incr_reload = 2'd3
    } addr_ctl_t;

    typedef enum logic [1:0] {
        start_immediate = 2'd0,
        start_vblank    = 2'd1,
        start_hblank    = 2'd2,
        start_never     = 2'd3      // no trigger source on this channel
    } start_t;

    typedef enum logic {
        width_half = 1'b0,
        width_word = 1'b1
    } xfer_width_t;

    // control fields as latched on enable rising
    typedef struct packed {
        addr_ctl_t   dest_ctl;
        addr_ctl_t   src_ctl;
        logic        repeat_on;
        xfer_width_t width;
        start_t      start;
        logic        irq_on;
    } dma_ctrl_t;

    typedef enum logic [1:0] {
        st_idle,
        st_waiting,
        st_reading,
        st_writing
    } engine_state_t;

endpackage

// ==== dma_props.sv ====
`timescale 1ns/1ns
`include "dma_config.svh"

module dma_props (
    input logic                    clk100,
    input logic                    reset,
    input logic                    mem_ena,
    input logic                    mem_rnw,
    input logic [`DMA_ADDR_W-1:0]  mem_adr,
    input logic                    mem_wide,
    input logic [`DMA_DATA_W-1:0]  mem_dout,
    input logic                    mem_done,
    input logic                    irq
);

    // request held steady until done
    a_req_hold: assert property (@(posedge clk100) disable iff (reset)
        mem_ena && !mem_done |=> mem_ena && $stable(mem_adr) && $stable(mem_rnw) &&
                                 $stable(mem_wide))
        else $error("memory request changed before mem_done");

    // write data must not move while the write is pending
    a_wdata_hold: assert property (@(posedge clk100) disable iff (reset)
        mem_ena && !mem_rnw && !mem_done |=> $stable(mem_dout))
        else $error("write data changed before mem_done");

    a_gap: assert property (@(posedge clk100) disable iff (reset)
        mem_ena && mem_done |=> !mem_ena)
        else $error("mem_ena still high after mem_done");

    a_irq_pulse: assert property (@(posedge clk100) disable iff (reset)
        irq |=> !irq)
        else $error("irq longer than one cycle");

endmodule

bind dma_engine dma_props props_i (
    .clk100   (clk100),
    .reset    (reset),
    .mem_ena  (mem_ena),
    .mem_rnw  (mem_rnw),
    .mem_adr  (mem_adr),
    .mem_wide (mem_wide),
    .mem_dout (mem_dout),
    .mem_done (mem_done),
    .irq      (irq)
);

// ==== dma_regs.sv ====
`timescale 1ns/1ns
`include "dma_config.svh"

module dma_regs import dma_pkg::*; (
    input  logic                        clk100,
    input  logic                        reset,
    input  logic                        reg_ena,
    input  logic                        reg_rnw,
    input  logic [`DMA_REG_ADR_W-1:0]   reg_adr,
    input  logic [3:0]                  reg_be,
    input  logic [31:0]                 reg_din,
    output logic [31:0]                 reg_dout,
    output logic                        reg_dout_valid,
    dma_cfg_if.regs                     cfg
);

    logic [`DMA_ADDR_W-1:0]   sad_q;
    logic [`DMA_ADDR_W-1:0]   dad_q;
    logic [`DMA_COUNT_W-1:0]  count_q;
    dma_ctrl_t                ctrl_q;       // as written
    logic                     enable_q;
    dma_ctrl_t                ctrl_lat_q;   // as seen by the engine
    logic [`DMA_ITEMS_W-1:0]  count_lat_q;
    logic                     arm_q;
    logic                     abort_q;

    logic                     wr_cnt;
    logic [31:0]              sad_new;
    logic [31:0]              dad_new;
    logic [31:0]              cnt_word;
    logic [31:0]              cnt_new;
    dma_ctrl_t                ctrl_new;
    logic [`DMA_ITEMS_W-1:0]  count_exp;

    function automatic logic [31:0] merge_be(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  be);
        logic [31:0] res;
        for (int i = 0; i < 4; i++) begin
            res[i*8 +: 8] = be[i] ? new_val[i*8 +: 8] : old_val[i*8 +: 8];
        end
        return res;
    endfunction

    assign wr_cnt = reg_ena && !reg_rnw && reg_adr == `DMA_REG_CNT;

    // cnt layout: en, irq, start, drq, width, repeat, src, dest, count in low half
    assign cnt_word = {enable_q, ctrl_q.irq_on, ctrl_q.start, 1'b0, ctrl_q.width,
                       ctrl_q.repeat_on, ctrl_q.src_ctl, ctrl_q.dest_ctl, 7'b0, count_q};

    always_comb begin
        sad_new            = merge_be({{(32-`DMA_ADDR_W){1'b0}}, sad_q}, reg_din, reg_be);
        dad_new            = merge_be({{(32-`DMA_ADDR_W){1'b0}}, dad_q}, reg_din, reg_be);
        cnt_new            = merge_be(cnt_word, reg_din, reg_be);
        ctrl_new.dest_ctl  = addr_ctl_t'(cnt_new[22:21]);
        ctrl_new.src_ctl   = addr_ctl_t'(cnt_new[24:23]);
        ctrl_new.repeat_on = cnt_new[25];
        ctrl_new.width     = xfer_width_t'(cnt_new[26]);
        ctrl_new.start     = start_t'(cnt_new[29:28]);
        ctrl_new.irq_on    = cnt_new[30];
    end

    // count of 0 means the full 16384 items
    assign count_exp = (cnt_new[`DMA_COUNT_W-1:0] == '0) ? `DMA_ITEMS_W'(`DMA_COUNT_MAX)
                                                        : {1'b0, cnt_new[`DMA_COUNT_W-1:0]};

    always_ff @(posedge clk100) begin
        if (reg_ena && !reg_rnw && reg_adr == `DMA_REG_SAD)
            sad_q <= sad_new[`DMA_ADDR_W-1:0];
        if (reg_ena && !reg_rnw && reg_adr == `DMA_REG_DAD)
            dad_q <= dad_new[`DMA_ADDR_W-1:0];
    end

    always_ff @(posedge clk100) begin
        if (reset) begin
            count_q     <= '0;
            ctrl_q      <= '0;
            enable_q    <= 1'b0;
            ctrl_lat_q  <= '0;
            count_lat_q <= '0;
            arm_q       <= 1'b0;
            abort_q     <= 1'b0;
        end else begin
            arm_q   <= 1'b0;
            abort_q <= 1'b0;
            if (cfg.done_disable)
                enable_q <= 1'b0;
            if (wr_cnt) begin
                count_q <= cnt_new[`DMA_COUNT_W-1:0];
                ctrl_q  <= ctrl_new;
                if (reg_be[3]) begin    // enable lives in the top byte
                    enable_q <= cnt_new[31];
                    abort_q  <= !cnt_new[31];
                    if (!enable_q && cnt_new[31]) begin
                        arm_q       <= 1'b1;
                        ctrl_lat_q  <= ctrl_new;
                        count_lat_q <= count_exp;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk100) begin
        if (reset)
            reg_dout_valid <= 1'b0;
        else
            reg_dout_valid <= reg_ena && reg_rnw;
    end

    always_ff @(posedge clk100) begin
        if (reg_ena && reg_rnw) begin
            case (reg_adr)
                `DMA_REG_CNT: reg_dout <= {cnt_word[31:16], 16'h0};  // count half reads 0
                default:      reg_dout <= '0;                        // sad/dad write-only
            endcase
        end
    end

    assign cfg.ctrl       = ctrl_lat_q;
    assign cfg.sad        = sad_q;
    assign cfg.dad        = dad_q;
    assign cfg.count_load = count_lat_q;
    assign cfg.arm        = arm_q;
    assign cfg.abort      = abort_q;

endmodule

// ==== dma_tb.sv ====
`timescale 1ns/1ns
`include "dma_config.svh"

module tb_dma;

    localparam int TMO = 400000;

    logic        clk100, reset;
    logic        reg_ena, reg_rnw;
    logic [1:0]  reg_adr;
    logic [3:0]  reg_be;
    logic [31:0] reg_din, reg_dout;
    logic        reg_dout_valid;
    logic        vblank_trigger, hblank_trigger;
    logic        mem_ena, mem_rnw, mem_wide, mem_done, irq, busy;
    logic [27:0] mem_adr;
    logic [31:0] mem_dout, mem_din;

    logic [31:0] mem_store[logic [27:0]];   // sparse, word addressed
    integer      seed = 57081;
    int          lat  = 0;
    logic [27:0] s_next;
    logic [31:0] rd;

    tb_clock_gen clk_i (.clk100(clk100), .reset(reset));

    dma_channel dut_i (.*);

    dma_checker chk_i (.clk100(clk100), .reset(reset), .mem_ena(mem_ena), .mem_rnw(mem_rnw),
                       .mem_adr(mem_adr), .mem_wide(mem_wide), .mem_dout(mem_dout),
                       .mem_done(mem_done), .irq(irq));

    function automatic logic [31:0] fill_word(input logic [27:0] a);
        return ({4'h0, a[27:2], 2'b00} * 32'h9E3779B1) ^ 32'h5A5A5A5A;
    endfunction

    function automatic logic [31:0] mem_read(input logic [27:0] a);
        logic [27:0] w;
        w = {a[27:2], 2'b00};
        return mem_store.exists(w) ? mem_store[w] : fill_word(w);
    endfunction

    function automatic logic [27:0] align(input logic [27:0] a, input bit wide);
        return wide ? {a[27:2], 2'b00} : {a[27:1], 1'b0};
    endfunction

    function automatic logic [27:0] step_addr(input logic [27:0] a, input logic [1:0] ctl,
                                              input bit wide, input bit force_up);
        logic [27:0] st;
        st = wide ? 28'd4 : 28'd2;
        if (force_up || ctl == 2'd0 || ctl == 2'd3)
            return a + st;
        else if (ctl == 2'd1)
            return a - st;
        return a;
    endfunction

    // reference: width, address and data of one write from the current source and destination
    function automatic logic [60:0] ref_write(input logic [27:0] s, input logic [27:0] d,
                                              input bit wide);
        logic [31:0] w;
        logic [15:0] h;
        w = mem_read(s);
        h = s[1] ? w[31:16] : w[15:0];
        return {wide, align(d, wide), wide ? w : {h, h}};
    endfunction

    task automatic build_expected(input logic [27:0] s_in, input logic [27:0] d_in,
                                  input int n, input logic [1:0] dctl, input logic [1:0] sctl,
                                  input bit wide, output logic [27:0] s_out);
        logic [27:0] s;
        logic [27:0] d;
        s = align(s_in, wide);
        d = align(d_in, wide);
        for (int i = 0; i < n; i++) begin
            chk_i.expect_write(ref_write(s, d, wide));
            s = step_addr(s, sctl, wide, s >= `DMA_ROM_LO && s < `DMA_ROM_HI);
            d = step_addr(d, dctl, wide, 1'b0);
        end
        s_out = s;
    endtask

    function automatic logic [31:0] cnt_val(input int n, input logic [1:0] dctl,
                                            input logic [1:0] sctl, input bit rep, input bit wide,
                                            input logic [1:0] start, input bit irq_on, input bit en);
        return {en, irq_on, start, 1'b0, wide, rep, sctl, dctl, 7'b0, 14'(n)};
    endfunction

    // memory model with random mem_done latency
    always @(posedge clk100) begin
        #1;
        if (mem_done) begin
            mem_done = 1'b0;
        end else if (mem_ena) begin
            if (lat == 0)
                lat = 1 + ($unsigned($random(seed)) % 4);
            lat--;
            if (lat == 0) begin
                mem_done = 1'b1;
                if (mem_rnw) begin
                    mem_din = mem_read(mem_adr);
                end else begin
                    rd = mem_wide ? mem_dout : mem_read(mem_adr);
                    if (!mem_wide && mem_adr[1])
                        rd[31:16] = mem_dout[31:16];
                    else if (!mem_wide)
                        rd[15:0] = mem_dout[15:0];
                    mem_store[{mem_adr[27:2], 2'b00}] = rd;
                end
            end
        end
    end

    task automatic reg_write(input logic [1:0] adr, input logic [31:0] data, input logic [3:0] be);
        @(posedge clk100);
        #1;
        reg_ena = 1'b1;
        reg_rnw = 1'b0;
        reg_adr = adr;
        reg_din = data;
        reg_be  = be;
        @(posedge clk100);
        #1 reg_ena = 1'b0;
    endtask

    task automatic reg_read(input logic [1:0] adr, output logic [31:0] data);
        int t;
        @(posedge clk100);
        #1;
        reg_ena = 1'b1;
        reg_rnw = 1'b1;
        reg_adr = adr;
        @(posedge clk100);
        #1 reg_ena = 1'b0;
        t = 0;
        while (!reg_dout_valid && t < 10) begin
            @(posedge clk100);
            #1 t++;
        end
        if (!reg_dout_valid)
            chk_i.note_failure("register read never returned valid data");
        data = reg_dout;
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (busy && t < TMO) begin
            @(posedge clk100);
            #1 t++;
        end
        if (busy)
            chk_i.note_failure("timeout waiting for busy to fall");
    endtask

    task automatic wait_irqs(input int n);
        int t;
        t = 0;
        while (chk_i.irq_cnt < n && t < TMO) begin
            @(posedge clk100);
            #1 t++;
        end
        if (chk_i.irq_cnt < n)
            chk_i.note_failure("timeout waiting for irq");
    endtask

    task automatic expect_quiet(input int cycles, input string what);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk100);
            #1;
            if (mem_ena) begin
                chk_i.note_failure(what);
                break;
            end
        end
    endtask

    task automatic pulse_vblank();
        @(posedge clk100);
        #1 vblank_trigger = 1'b1;
        @(posedge clk100);
        #1 vblank_trigger = 1'b0;
    endtask

    task automatic run_imm(input logic [27:0] s, input logic [27:0] d, input int n,
                           input logic [1:0] dctl, input logic [1:0] sctl, input bit wide);
        logic [27:0] s_end;
        build_expected(s, d, (n == 0) ? `DMA_COUNT_MAX : n, dctl, sctl, wide, s_end);
        reg_write(`DMA_REG_SAD, {4'h0, s}, 4'hF);
        reg_write(`DMA_REG_DAD, {4'h0, d}, 4'hF);
        reg_write(`DMA_REG_CNT, cnt_val(n, dctl, sctl, 0, wide, 2'd0, 1, 1), 4'hF);
        repeat (2) @(posedge clk100);
        #1 wait_idle();
    endtask

    initial begin
        int          t;
        logic [31:0] cnt_exp;
        logic [31:0] cnt_rb;
        reg_ena = 0;
        reg_rnw = 0;
        reg_adr = 0;
        reg_be = 0;
        reg_din = 0;
        vblank_trigger = 0;
        hblank_trigger = 0;
        mem_din = 0;
        mem_done = 0;
        t = 0;
        while (reset !== 1'b0 && t < 20) begin
            @(posedge clk100);
            t++;
        end
        if (reset !== 1'b0)
            chk_i.note_failure("reset was never released");
        #1;

        run_imm(28'h3000000, 28'h2000000, 8, 2'd0, 2'd0, 1);
        chk_i.end_test("word_incr", 8, 1);

        run_imm(28'h3000102, 28'h2001000, 3, 2'd1, 2'd2, 0);  // fixed src, upper lane
        chk_i.end_test("half_dest_decr", 3, 1);
        run_imm(28'h3000202, 28'h2002000, 4, 2'd2, 2'd0, 0);
        chk_i.end_test("half_dest_fixed", 4, 1);

        run_imm(28'h8000100, 28'h2100000, 0, 2'd0, 2'd1, 1);  // rom source, decr ignored
        chk_i.end_test("rom_count0", `DMA_COUNT_MAX, 1);

        // vblank with repeat, destination reloaded
        build_expected(28'h3010000, 28'h2200000, 4, 2'd3, 2'd0, 1, s_next);
        build_expected(s_next, 28'h2200000, 4, 2'd3, 2'd0, 1, s_next);
        reg_write(`DMA_REG_SAD, 32'h3010000, 4'hF);
        reg_write(`DMA_REG_DAD, 32'h2200000, 4'hF);
        reg_write(`DMA_REG_CNT, cnt_val(4, 2'd3, 2'd0, 1, 1, 2'd1, 1, 1), 4'hF);
        expect_quiet(20, "memory accessed before vblank trigger");
        pulse_vblank();
        wait_irqs(1);
        expect_quiet(20, "memory accessed before second vblank trigger");
        pulse_vblank();
        wait_irqs(2);
        reg_write(`DMA_REG_CNT, 32'h0, 4'h8);
        repeat (2) @(posedge clk100);
        #1 wait_idle();
        chk_i.end_test("vblank_repeat", 8, 2);

        // read-back after a non-repeat transfer, dest decr and src fixed
        run_imm(28'h3020000, 28'h2300000, 2, 2'd1, 2'd2, 1);
        cnt_exp = cnt_val(2, 2'd1, 2'd2, 0, 1, 2'd0, 1, 0);
        cnt_exp[15:0] = 16'h0;      // count half reads 0
        reg_read(`DMA_REG_CNT, cnt_rb);
        if (cnt_rb !== cnt_exp)
            chk_i.note_failure($sformatf("ERR reg_dout exp %h got %h", cnt_exp, cnt_rb));
        reg_write(`DMA_REG_CNT, cnt_val(4, 2'd0, 2'd0, 0, 1, 2'd1, 1, 1), 4'hF);
        repeat (3) @(posedge clk100);
        reg_write(`DMA_REG_CNT, 32'h0, 4'h8);   // disable while waiting
        pulse_vblank();
        expect_quiet(30, "memory accessed after channel was disabled");
        wait_idle();
        chk_i.end_test("readback_abort", 2, 1);

        $display("tests %0d, failed %0d, errors %0d",
                 chk_i.tests_run, chk_i.tests_bad, chk_i.err_count);
        if (chk_i.err_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f compile.f --top-module tb_dma -o sim_dma

./obj_dir/sim_dma > sim.log 2>&1 || true
cat sim.log

grep -q "^Testbench passed$" sim.log

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk100,
    output logic reset
);

    initial begin
        clk100 = 1'b0;
        forever #2 clk100 = ~clk100;    // 4 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk100);
        #1 reset = 1'b0;
    end

endmodule
